// File: hdl/matmul_pkg.sv
`default_nettype none

// shared types and pipeline constants for the matrix multiply engine
package matmul_pkg;

    // controller states, RUN issues one MAC operation per cycle
    typedef enum logic [1:0] {
        IDLE,   // waiting for an accepted start
        RUN,    // walking the loops and issuing operations
        DRAIN   // last operation issued, waiting for the final write
    } ctrl_state_t;

    // operation carried alongside each issued address pair
    typedef enum logic [1:0] {
        MAC_IDLE,   // nothing this cycle
        MAC_LOAD,   // first product of an element replaces the accumulator
        MAC_ACC     // product is added to the running sum
    } mac_op_t;

    localparam int READ_LATENCY = 1;                  // sp_ram read delay in cycles
    localparam int PIPE_DEPTH   = READ_LATENCY + 1;   // issue to result write, incl. MAC reg

endpackage

`default_nettype wire

// File: hdl/sp_ram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual address memory with one write port and one registered read port
// used for both operand matrices and for the result matrix
module sp_ram #(
    parameter  int WIDTH = 8,
    parameter  int DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  wire             clk,

    input  wire             wr_en,
    input  wire [AW-1:0]    wr_addr,
    input  wire [WIDTH-1:0] wr_data,

    input  wire [AW-1:0]    rd_addr,
    output logic [WIDTH-1:0] rd_data    // valid the cycle after rd_addr
);

    // storage array, contents persist across runs so the host can reuse operands
    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;    // host load or MAC result write
        end
        // a read of the address being written returns the old word
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/addr_ctr.sv
`timescale 1ns/1ps
`default_nettype none

// walks the three nested loops of the product
// innermost is the accumulation index, then output column, then output row
module addr_ctr #(
    parameter  int M      = 3,
    parameter  int N      = 4,
    parameter  int MAXK   = 5,
    localparam int K_BITS = $clog2(MAXK + 1),
    localparam int A_AW   = $clog2(M * MAXK),
    localparam int B_AW   = $clog2(MAXK * N),
    localparam int OUT_AW = $clog2(M * N),
    localparam int ROW_W  = (M > 1) ? $clog2(M) : 1,
    localparam int COL_W  = (N > 1) ? $clog2(N) : 1
) (
    input  wire               clk,
    input  wire               reset,

    input  wire [K_BITS-1:0]  k,            // run time inner dimension, held while busy
    input  wire               incr_acc,     // one issue this cycle
    input  wire               incr_outaddr, // result write this cycle

    output logic [A_AW-1:0]   a_addr,
    output logic [B_AW-1:0]   b_addr,
    output logic [OUT_AW-1:0] out_addr,

    output logic              last_acc,     // current issue closes an element
    output logic              last_index,   // current issue belongs to the last element
    output logic              compute_finished
);
    import matmul_pkg::*;

    logic [K_BITS-1:0] acc_idx;     // innermost loop, 0 to k-1
    logic [COL_W-1:0]  col_idx;     // output column, 0 to N-1
    logic [ROW_W-1:0]  row_idx;     // output row, 0 to M-1

    logic last_col;
    logic last_row;
    logic incr_col;
    logic incr_row;

    // last_index delayed to the write stage of the pipeline
    logic [PIPE_DEPTH-1:0] last_index_d;
    logic                  last_write;

    assign last_acc = (acc_idx == k - K_BITS'(1));
    assign last_col = (col_idx == COL_W'(N - 1));
    assign last_row = (row_idx == ROW_W'(M - 1));

    assign incr_col = incr_acc && last_acc;               // inner wrap advances the column
    assign incr_row = incr_acc && last_acc && last_col;   // column wrap advances the row

    assign last_index = last_col && last_row;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_idx <= '0;
            col_idx <= '0;
            row_idx <= '0;
        end else begin
            if (incr_acc) begin
                acc_idx <= last_acc ? '0 : acc_idx + K_BITS'(1);
            end
            if (incr_col) begin
                col_idx <= last_col ? '0 : col_idx + COL_W'(1);
            end
            if (incr_row) begin
                row_idx <= last_row ? '0 : row_idx + ROW_W'(1);
            end
        end
    end

    // the input loops are already on the last element while the write side
    // is still storing earlier sums, so the wrap test has to see the flag
    // from the issue cycle that produced the write
    always_ff @(posedge clk) begin
        if (reset) begin
            last_index_d <= '0;
        end else begin
            last_index_d <= {last_index_d[PIPE_DEPTH-2:0], last_index};
        end
    end

    assign last_write = last_index_d[PIPE_DEPTH-1];

    // result address steps in the same cycle as the result write
    always_ff @(posedge clk) begin
        if (reset) begin
            out_addr <= '0;
        end else if (incr_outaddr) begin
            out_addr <= last_write ? '0 : out_addr + OUT_AW'(1);
        end
    end

    assign compute_finished = incr_outaddr && last_write;   // coincides with the last write

    // A is stored row major with stride k, B row major with stride N
    assign a_addr = A_AW'(acc_idx) + A_AW'(row_idx) * A_AW'(k);
    assign b_addr = B_AW'(col_idx) + B_AW'(acc_idx) * B_AW'(N);

endmodule

`default_nettype wire

// File: hdl/matmul_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// run control for the engine
// accepts start, drives the loop counter and tags every issue with a MAC operation
module matmul_ctrl #(
    parameter  int MAXK   = 5,
    localparam int K_BITS = $clog2(MAXK + 1)
) (
    input  wire                 clk,
    input  wire                 reset,

    input  wire                 start,
    input  wire [K_BITS-1:0]    k,

    input  wire                 last_acc,
    input  wire                 last_index,
    input  wire                 compute_finished,

    output logic                incr_acc,
    output matmul_pkg::mac_op_t mac_op,
    output logic                busy
);
    import matmul_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    logic start_ok;     // start seen with a legal k
    logic first_acc;    // next issue is accumulation index zero

    // k of zero or above MAXK would make the loops meaningless, so such a start is dropped
    assign start_ok = start && (k != '0) && (k <= K_BITS'(MAXK));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_ok) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                // the issue this cycle is the final one of the whole product
                if (last_acc && last_index) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (compute_finished) begin
                    state_nxt = IDLE;   // last result is being written now
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the previous issue closed an element, so this one starts a new sum
    always_ff @(posedge clk) begin
        if (reset) begin
            first_acc <= 1'b1;
        end else if (incr_acc) begin
            first_acc <= last_acc;  // the last issue of a run always closes an element
        end
    end

    assign incr_acc = (state == RUN);   // one issue per cycle while running
    assign busy     = (state != IDLE);  // covers RUN and the drain of the pipeline

    always_comb begin
        if (!incr_acc) begin
            mac_op = MAC_IDLE;
        end else if (first_acc) begin
            mac_op = MAC_LOAD;
        end else begin
            mac_op = MAC_ACC;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

// multiply accumulate stage behind the operand memories
// operations arrive with the addresses and are staged to meet the read data
module mac_unit #(
    parameter int INW  = 8,
    parameter int OUTW = 20
) (
    input  wire                 clk,
    input  wire                 reset,

    input  wire matmul_pkg::mac_op_t mac_op,    // issued with the read addresses
    input  wire [INW-1:0]       a_data,
    input  wire [INW-1:0]       b_data,

    output logic [OUTW-1:0]     result,
    output logic                result_valid    // write enable of the result memory
);
    import matmul_pkg::*;

    mac_op_t op_pipe [READ_LATENCY];    // operation delay matching the memory read
    mac_op_t op_q;                      // staged operation, lines up with a_data and b_data

    logic [2*INW-1:0] product;
    logic [OUTW-1:0]  product_ext;      // product brought to the accumulator width
    logic [OUTW-1:0]  acc;
    logic             acc_live;         // accumulator holds a sum not yet written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
                op_pipe[i] <= MAC_IDLE;
            end
        end else begin
            op_pipe[0] <= mac_op;
            for (int i = 1; i < READ_LATENCY; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
        end
    end

    assign op_q = op_pipe[READ_LATENCY-1];

    assign product     = a_data * b_data;   // unsigned full width product
    assign product_ext = OUTW'(product);    // sums wrap modulo 2**OUTW

    always_ff @(posedge clk) begin
        case (op_q)
            MAC_LOAD: acc <= product_ext;           // previous element is dropped here
            MAC_ACC:  acc <= acc + product_ext;
            default:  acc <= acc;
        endcase
    end

    // set for the cycle after any staged load or add
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_live <= 1'b0;
        end else begin
            acc_live <= (op_q != MAC_IDLE);
        end
    end

    // a sum is complete once the next staged operation does not extend it,
    // which lets a write overlap the load of the following element
    assign result_valid = acc_live && (op_q != MAC_ACC);
    assign result       = acc;

endmodule

`default_nettype wire

// File: hdl/matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

// matrix multiply engine, result = A (M x k) times B (k x N)
module matmul_top #(
    parameter  int INW    = 8,
    parameter  int OUTW   = 20,
    parameter  int M      = 3,
    parameter  int N      = 4,
    parameter  int MAXK   = 5,
    localparam int K_BITS = $clog2(MAXK + 1),
    localparam int A_AW   = $clog2(M * MAXK),
    localparam int B_AW   = $clog2(MAXK * N),
    localparam int OUT_AW = $clog2(M * N)
) (
    input  wire                clk,
    input  wire                reset,

    // host load of A, element (r,c) at r*k+c
    input  wire                a_wr_en,
    input  wire [A_AW-1:0]     a_wr_addr,
    input  wire [INW-1:0]      a_wr_data,

    // host load of B, element (r,c) at r*N+c
    input  wire                b_wr_en,
    input  wire [B_AW-1:0]     b_wr_addr,
    input  wire [INW-1:0]      b_wr_data,

    // run control
    input  wire [K_BITS-1:0]   k,
    input  wire                start,
    output logic               busy,
    output logic               done,

    // host read of the result, one cycle latency
    input  wire [OUT_AW-1:0]   res_rd_addr,
    output logic [OUTW-1:0]    res_rd_data
);
    import matmul_pkg::*;

    logic              incr_acc;
    mac_op_t           mac_op;
    logic              last_acc;
    logic              last_index;
    logic              compute_finished;

    logic [A_AW-1:0]   a_addr;
    logic [B_AW-1:0]   b_addr;
    logic [OUT_AW-1:0] out_addr;
    logic [INW-1:0]    a_rd_data;
    logic [INW-1:0]    b_rd_data;

    logic [OUTW-1:0]   result;
    logic              result_valid;   // also steps the result address

    matmul_ctrl #(.MAXK(MAXK)) u_ctrl (
        .clk(clk), .reset(reset),
        .start(start), .k(k),
        .last_acc(last_acc), .last_index(last_index), .compute_finished(compute_finished),
        .incr_acc(incr_acc), .mac_op(mac_op), .busy(busy)
    );

    addr_ctr #(.M(M), .N(N), .MAXK(MAXK)) u_addr_ctr (
        .clk(clk), .reset(reset),
        .k(k), .incr_acc(incr_acc), .incr_outaddr(result_valid),
        .a_addr(a_addr), .b_addr(b_addr), .out_addr(out_addr),
        .last_acc(last_acc), .last_index(last_index),
        .compute_finished(compute_finished)
    );

    assign done = compute_finished;     // one cycle pulse on the last result write

    sp_ram #(.WIDTH(INW), .DEPTH(M * MAXK)) a_mem (
        .clk(clk),
        .wr_en(a_wr_en), .wr_addr(a_wr_addr), .wr_data(a_wr_data),
        .rd_addr(a_addr), .rd_data(a_rd_data)
    );

    sp_ram #(.WIDTH(INW), .DEPTH(MAXK * N)) b_mem (
        .clk(clk),
        .wr_en(b_wr_en), .wr_addr(b_wr_addr), .wr_data(b_wr_data),
        .rd_addr(b_addr), .rd_data(b_rd_data)
    );

    mac_unit #(.INW(INW), .OUTW(OUTW)) u_mac (
        .clk(clk), .reset(reset),
        .mac_op(mac_op), .a_data(a_rd_data), .b_data(b_rd_data),
        .result(result), .result_valid(result_valid)
    );

    // written by the MAC, read by the host once done has pulsed
    sp_ram #(.WIDTH(OUTW), .DEPTH(M * N)) res_mem (
        .clk(clk),
        .wr_en(result_valid), .wr_addr(out_addr), .wr_data(result),
        .rd_addr(res_rd_addr), .rd_data(res_rd_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_matmul_model.svh
`ifndef TB_MATMUL_MODEL_SVH
`define TB_MATMUL_MODEL_SVH

// reference model of the matrix product, included inside tb_matmul
// it relies on the size parameters of the module that includes it

localparam logic [31:0] LFSR_SEED = 32'h9817c147;

logic [31:0]     lfsr_state = LFSR_SEED;
logic [INW-1:0]  a_img [M*MAXK];    // image of what the host wrote into the A memory
logic [INW-1:0]  b_img [MAXK*N];    // image of the B memory, row major with stride N
logic [OUTW-1:0] expected [M*N];    // model result, row major like the result memory

// one step of a 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// gathers nbits fresh bits, the register steps once for every bit
function automatic logic [31:0] take_random_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};   // newest bit enters at the bottom
    end
    return v;
endfunction

// plain triple loop over the memory images
// A is read with the run time stride kv, so any k works on the same image
task automatic compute_expected(input int kv);
    logic [OUTW-1:0]  sum;
    logic [2*INW-1:0] prod;
    for (int r = 0; r < M; r++) begin
        for (int c = 0; c < N; c++) begin
            sum = '0;
            for (int i = 0; i < kv; i++) begin
                prod = a_img[r*kv + i] * b_img[i*N + c];   // full width unsigned product
                sum  = sum + OUTW'(prod);                   // wraps at the result width
            end
            expected[r*N + c] = sum;
        end
    end
endtask

`endif

// File: testbench/tb_matmul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;
    import matmul_pkg::*;

    localparam int INW = 8;
    localparam int OUTW = 20;
    localparam int M = 3;
    localparam int N = 4;
    localparam int MAXK = 5;
    localparam int K_BITS = $clog2(MAXK + 1);
    localparam int A_AW = $clog2(M * MAXK);
    localparam int B_AW = $clog2(MAXK * N);
    localparam int OUT_AW = $clog2(M * N);
    localparam int A_DEPTH = M * MAXK;
    localparam int B_DEPTH = MAXK * N;
    localparam int LOAD_CYCLES = (A_DEPTH > B_DEPTH) ? A_DEPTH : B_DEPTH;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM = 6;
    localparam int NUM_RUNS = NUM_RANDOM + 5;  // directed, randoms, all ones, two back to back, one more

    `include "tb_matmul_model.svh"

    logic clk = 1'b0;
    logic reset;
    logic a_wr_en, b_wr_en, start;
    logic [A_AW-1:0] a_wr_addr;
    logic [B_AW-1:0] b_wr_addr;
    logic [INW-1:0] a_wr_data, b_wr_data;
    logic [K_BITS-1:0] k;
    logic [OUT_AW-1:0] res_rd_addr;
    logic busy, done;
    logic [OUTW-1:0] res_rd_data;

    string test_name = "reset";
    int k_plan [NUM_RUNS];      // k of every run, drawn up front so the cycle limit is known
    int cycle_cnt = 0;
    int cycle_limit = 0;
    int error_count = 0;
    logic checking = 1'b0;      // busy and done are watched once reset is released
    logic busy_expected = 1'b0; // both set on the rising edge for the cycle that follows
    logic done_expected = 1'b0;
    ctrl_state_t stuck_state;

    matmul_top #(.INW(INW), .OUTW(OUTW), .M(M), .N(N), .MAXK(MAXK)) i_dut (
        .clk(clk), .reset(reset),
        .a_wr_en(a_wr_en), .a_wr_addr(a_wr_addr), .a_wr_data(a_wr_data),
        .b_wr_en(b_wr_en), .b_wr_addr(b_wr_addr), .b_wr_data(b_wr_data),
        .k(k), .start(start), .busy(busy), .done(done),
        .res_rd_addr(res_rd_addr), .res_rd_data(res_rd_data)
    );

    always #10 clk = ~clk;      // 20 ns period

    task automatic stop_with_failure();
        error_count++;
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("MISMATCH test %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
        stop_with_failure();
    endtask

    // a plain cycle with no run in progress, so busy and done must stay low
    task automatic idle_cycle();
        @(posedge clk);
        busy_expected = 1'b0;
        done_expected = 1'b0;
    endtask

    // mode 0 is an address pattern, 1 is random, 2 is all ones
    task automatic fill_operands(input int mode);
        for (int i = 0; i < A_DEPTH; i++) begin
            a_img[i] = (mode == 0) ? INW'(i*37 + 11) : (mode == 1) ? INW'(take_random_bits(INW)) : '1;
        end
        for (int i = 0; i < B_DEPTH; i++) begin
            b_img[i] = (mode == 0) ? INW'(i*23 + 200) : (mode == 1) ? INW'(take_random_bits(INW)) : '1;
        end
    endtask

    // A and B are written side by side, the shorter memory finishes early
    task automatic load_operands();
        for (int i = 0; i < LOAD_CYCLES; i++) begin
            idle_cycle();
            a_wr_en   <= (i < A_DEPTH);
            a_wr_addr <= A_AW'(i % A_DEPTH);
            a_wr_data <= a_img[i % A_DEPTH];
            b_wr_en   <= (i < B_DEPTH);
            b_wr_addr <= B_AW'(i % B_DEPTH);
            b_wr_data <= b_img[i % B_DEPTH];
        end
        idle_cycle();
        a_wr_en <= 1'b0;
        b_wr_en <= 1'b0;
    endtask

    // pulses start and follows the run until done, the negedge monitor checks every cycle
    // extra_start_cyc places a second start pulse inside the run, -1 for none
    task automatic run_product(input int kv, input int extra_start_cyc);
        int cyc;
        int done_cyc;
        logic done_seen;
        cyc = 0;
        done_cyc = M * N * kv + PIPE_DEPTH;    // last write lands here
        done_seen = 1'b0;
        idle_cycle();                          // start cycle, busy rises one cycle later
        k     <= K_BITS'(kv);
        start <= 1'b1;
        while (!done_seen) begin
            @(negedge clk);
            done_seen = done;
            if (!done_seen) begin
                @(posedge clk);
                cyc++;
                busy_expected = 1'b1;
                done_expected = (cyc == done_cyc);
                start <= (cyc == extra_start_cyc);
            end
        end
    endtask

    // one read per cycle, each word is compared one cycle after its address
    task automatic read_and_check();
        for (int i = 0; i <= M * N; i++) begin
            idle_cycle();
            if (i < M * N) begin
                res_rd_addr <= OUT_AW'(i);
            end
            @(negedge clk);
            if (i > 0) begin
                assert (res_rd_data === expected[i-1])
                    else report_mismatch($sformatf("result[%0d]", i-1), expected[i-1], res_rd_data);
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            assert (done === done_expected) else report_mismatch("done", done_expected, done);
            assert (busy === busy_expected) else report_mismatch("busy", busy_expected, busy);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stuck_state = i_dut.u_ctrl.state;
            $display("timeout in test %s after %0d cycles, controller still in %s",
                     test_name, cycle_cnt, stuck_state.name());
            stop_with_failure();
        end
    end

    initial begin
        reset = 1'b1;
        a_wr_en = 1'b0;
        a_wr_addr = '0;
        a_wr_data = '0;
        b_wr_en = 1'b0;
        b_wr_addr = '0;
        b_wr_data = '0;
        k = K_BITS'(1);
        start = 1'b0;
        res_rd_addr = '0;

        k_plan[0] = 1;
        for (int i = 1; i <= NUM_RANDOM; i++) begin
            k_plan[i] = take_random_bits(3) % MAXK + 1;
        end
        k_plan[NUM_RANDOM+1] = MAXK;
        k_plan[NUM_RANDOM+2] = take_random_bits(3) % MAXK + 1;
        k_plan[NUM_RANDOM+3] = k_plan[NUM_RANDOM+2] % MAXK + 1;    // always differs from the run before
        k_plan[NUM_RANDOM+4] = take_random_bits(3) % MAXK + 1;
        cycle_limit = RESET_CYCLES;
        foreach (k_plan[i]) begin
            cycle_limit += M * N * k_plan[i] + 40;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        checking = 1'b1;

        test_name = "directed_k1";
        fill_operands(0);
        load_operands();
        run_product(k_plan[0], -1);
        compute_expected(k_plan[0]);
        read_and_check();

        for (int i = 1; i <= NUM_RANDOM; i++) begin
            test_name = $sformatf("random_%0d_k%0d", i, k_plan[i]);
            fill_operands(1);
            load_operands();
            run_product(k_plan[i], -1);
            compute_expected(k_plan[i]);
            read_and_check();
        end

        // every element is MAXK products of the largest operands
        test_name = "all_ones";
        fill_operands(2);
        load_operands();
        run_product(MAXK, -1);
        for (int i = 0; i < M * N; i++) begin
            expected[i] = OUTW'(MAXK * (2**INW - 1) * (2**INW - 1));
        end
        read_and_check();

        // the second start lands in the cycle right after done, only its results survive
        test_name = "back_to_back";
        fill_operands(1);
        load_operands();
        run_product(k_plan[NUM_RANDOM+2], -1);
        run_product(k_plan[NUM_RANDOM+3], -1);
        compute_expected(k_plan[NUM_RANDOM+3]);
        read_and_check();

        // start with k of zero while idle, then a start pulse in the drain of the real run
        test_name = "ignored_starts";
        idle_cycle();
        k     <= '0;
        start <= 1'b1;
        idle_cycle();
        start <= 1'b0;
        run_product(k_plan[NUM_RANDOM+4], M * N * k_plan[NUM_RANDOM+4] + 1);
        compute_expected(k_plan[NUM_RANDOM+4]);
        read_and_check();

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+testbench
hdl/matmul_pkg.sv
hdl/sp_ram.sv
hdl/addr_ctr.sv
hdl/matmul_ctrl.sv
hdl/mac_unit.sv
hdl/matmul_top.sv
testbench/tb_matmul.sv
